// ==== all.f ====
+incdir+common
common/spi_bus_pkg.sv
spi1/spi_byte_link.sv
spi1/spi1_controller.sv
hdl/bus_ram.sv
hdl/spi_bridge_top.sv
testbench/clock_gen.sv
testbench/spi_host_driver.sv
testbench/spi_bridge_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module spi_bridge_tb -f all.f
	./obj_dir/Vspi_bridge_tb | awk '{ print } /^RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== testbench/spi_bridge_tb.sv ====
// Random traffic checked against a byte model; reads only target locations written before
`include "spi_bus_consts.svh"

module spi_bridge_tb;

    localparam int CYCLE_LIMIT = 400 * 32 * 16 + 51200;   // Ops x bits x sck period plus framing

    logic                      clk;
    logic                      rst_n;
    logic                      sck;
    logic                      cs_n;
    logic                      pico;
    logic                      poci;
    logic                      stall;
    logic [7:0]                model_mem [1 << `RAM_ADDR_BITS];
    logic [`RAM_ADDR_BITS-1:0] written_q [$];
    logic [`SPI_ADDR_W-1:0]    last_addr;
    logic [31:0]               lcg_state = 32'hecd2b104;
    int                        errors = 0;
    int                        checks = 0;
    int                        cycles = 0;

    clock_gen clk0 (.clk_o(clk));

    spi_host_driver host0 (
        .clk     (clk),
        .poci_i  (poci),
        .stall_i (stall),
        .sck_o   (sck),
        .cs_n_o  (cs_n),
        .pico_o  (pico)
    );

    spi_bridge_top dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .spi_sck_i   (sck),
        .spi_cs_n_i  (cs_n),
        .spi_pico_i  (pico),
        .spi_poci_o  (poci),
        .spi_stall_o (stall)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic write_and_model(input logic [`SPI_ADDR_W-1:0] addr, input logic [7:0] data);
        host0.write_at(addr, data);
        model_mem[addr[`RAM_ADDR_BITS-1:0]] = data;   // Upper bits alias
        written_q.push_back(addr[`RAM_ADDR_BITS-1:0]);
        last_addr = addr;
    endtask

    task automatic compare_reply(input logic [`SPI_ADDR_W-1:0] addr, input logic [7:0] got);
        logic [7:0] expected;
        expected = model_mem[addr[`RAM_ADDR_BITS-1:0]];
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR spi_poci_o at %05h: got %02h expected %02h", addr, got, expected);
        end
    endtask

    task automatic check_read_at(input logic [`SPI_ADDR_W-1:0] addr);
        logic [7:0] got;
        host0.read_at(addr, got);
        last_addr = addr;
        compare_reply(addr, got);
    endtask

    task automatic check_read_next();
        logic [7:0] got;
        last_addr = last_addr + 17'd1;   // Wraps at 17 bits
        host0.read_next(got);
        compare_reply(last_addr, got);
    endtask

    // Five consecutive writes then READ_NEXT after a READ_AT and after a WRITE_AT
    task automatic run_chain(input logic [`SPI_ADDR_W-1:0] base);
        logic [31:0]            r;
        logic [`SPI_ADDR_W-1:0] a;
        a = base;
        repeat (5) begin
            r = next_random();
            write_and_model(a, r[31:24]);
            a = a + 17'd1;
        end
        check_read_at(base);
        repeat (4) check_read_next();
        r = next_random();
        write_and_model(base, r[31:24]);
        repeat (4) check_read_next();
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d clock cycles without reaching the end of the tests",
                     CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0]            r;
        logic [31:0]            d;
        logic [`SPI_ADDR_W-1:0] a;
        int                     n;
        int                     pick;
        rst_n <= 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        checks++;
        if (stall !== 1'b0) begin
            errors++;
            $display("ERR spi_stall_o after reset: got %h expected %h", stall, 1'b0);
        end
        for (n = 0; n < 200; n++) begin
            r = next_random();
            d = next_random();
            write_and_model(r[31:15], d[31:24]);
            if (d[23]) begin
                pick = int'(d[15:8]) % written_q.size();
                a    = {d[22:16], written_q[pick]};   // Earlier location with random upper bits
                check_read_at(a);
            end
        end
        for (n = 0; n < 3; n++) begin
            r = next_random();
            run_chain((n == 0) ? 17'h1fffe : r[31:15]);   // First chain wraps past 1FFFF
        end
        for (n = 0; n < 6; n++) begin
            r = next_random();
            d = next_random();
            a = {r[31:25] ^ (d[15:9] | 7'h01), r[24:15]};   // Same RAM word under other upper bits
            write_and_model(r[31:15], d[31:24]);
            check_read_at(a);
        end
        for (n = 0; n < 3; n++) begin
            r = next_random();
            d = next_random();
            write_and_model(r[31:15], d[31:24]);
            host0.abort_write(r[31:15]);
            check_read_at(r[31:15]);
            write_and_model(r[31:15], d[23:16]);
            check_read_at(r[31:15]);
        end
        $display("Checks %0d, data errors %0d, stall errors %0d",
                 checks, errors, host0.stall_errors);
        if (errors == 0 && host0.stall_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/spi_host_driver.sv ====
// SPI mode 0 host at clk/16 with one command per cs frame; the reply byte is clocked out as 00
`include "spi_bus_consts.svh"

module spi_host_driver (
    input  logic clk,
    input  logic poci_i,
    input  logic stall_i,
    output logic sck_o,
    output logic cs_n_o,
    output logic pico_o
);

    int stall_errors = 0;

    initial begin
        sck_o  <= 1'b0;
        cs_n_o <= 1'b1;   // Target deselected
        pico_o <= 1'b0;
    end

    // pico changes with the falling sck and poci is sampled just before the rise
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        logic [7:0] tx_left;
        tx_left = tx;
        rx      = 8'h00;
        repeat (8) begin
            @(posedge clk);
            sck_o  <= 1'b0;
            pico_o <= tx_left[7];
            tx_left = {tx_left[6:0], 1'b0};
            repeat (7) @(posedge clk);
            @(negedge clk);
            rx = {rx[6:0], poci_i};
            @(posedge clk);
            sck_o <= 1'b1;
            repeat (7) @(posedge clk);
        end
        @(posedge clk);
        sck_o <= 1'b0;
        repeat (7) @(posedge clk);
    endtask

    task automatic run_frame(input logic [31:0] frame_bytes, input int n_bytes,
                             input logic want_reply, output logic [7:0] reply);
        logic [31:0] bytes_left;
        logic [7:0]  ignored;
        int          waited;
        bytes_left = frame_bytes;
        waited     = 0;
        reply      = 8'h00;
        @(posedge clk);
        cs_n_o <= 1'b0;
        repeat (8) @(posedge clk);   // Lets cs through the synchronizer
        repeat (n_bytes) begin
            shift_byte(bytes_left[31:24], ignored);
            bytes_left = {bytes_left[23:0], 8'h00};
        end
        @(negedge clk);
        while (stall_i !== 1'b0 && waited <= 64) begin
            @(negedge clk);
            waited++;
        end
        if (waited > 64) begin
            stall_errors++;
            $display("Stall stayed high for more than 64 cycles after a command");
        end
        if (want_reply) begin
            shift_byte(8'h00, reply);
        end
        @(posedge clk);
        cs_n_o <= 1'b1;
        pico_o <= 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        if (stall_i !== 1'b0) begin
            stall_errors++;
            $display("ERR spi_stall_o after cs release: got %h expected %h", stall_i, 1'b0);
        end
    endtask

    task automatic write_at(input logic [`SPI_ADDR_W-1:0] addr, input logic [7:0] data);
        logic [7:0] ignored;
        run_frame({`OP_WRITE_AT, 4'b0000, addr[16], addr[15:0], data}, 4, 1'b0, ignored);
    endtask

    task automatic read_at(input logic [`SPI_ADDR_W-1:0] addr, output logic [7:0] data);
        run_frame({`OP_READ_AT, 4'b0000, addr[16], addr[15:0], 8'h00}, 3, 1'b1, data);
    endtask

    task automatic read_next(output logic [7:0] data);
        run_frame({`OP_READ_NEXT, 5'b00000, 24'h000000}, 1, 1'b1, data);
    endtask

    // Address sent, data byte never clocked
    task automatic abort_write(input logic [`SPI_ADDR_W-1:0] addr);
        logic [7:0] ignored;
        run_frame({`OP_WRITE_AT, 4'b0000, addr[16], addr[15:0], 8'h00}, 3, 1'b0, ignored);
    endtask

endmodule

// ==== testbench/clock_gen.sv ====
// Free-running testbench clock with a period of 40 time units, starts low
module clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;   // Half period
    end

endmodule

// ==== hdl/spi_bridge_top.sv ====
// SPI to memory bus bridge; sck at most clk/8, host waits for stall low before a read reply
`include "spi_bus_consts.svh"

module spi_bridge_top (
    input  logic clk,
    input  logic rst_n_i,
    input  logic spi_sck_i,
    input  logic spi_cs_n_i,
    input  logic spi_pico_i,
    output logic spi_poci_o,
    output logic spi_stall_o
);

    logic [`SPI_DATA_W-1:0] rx_byte;
    logic                   rx_valid;
    logic                   cs_start;
    logic                   cs_active;
    logic [`SPI_DATA_W-1:0] tx_byte;
    spi_bus_pkg::bus_req_t  req;
    logic                   req_valid;
    logic                   req_ready;
    spi_bus_pkg::bus_rsp_t  rsp;

    spi_byte_link u_link (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .spi_sck_i   (spi_sck_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_pico_i  (spi_pico_i),
        .spi_poci_o  (spi_poci_o),
        .tx_byte_i   (tx_byte),
        .rx_byte_o   (rx_byte),
        .rx_valid_o  (rx_valid),
        .cs_start_o  (cs_start),
        .cs_active_o (cs_active)
    );

    spi1_controller u_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_byte_i   (rx_byte),
        .rx_valid_i  (rx_valid),
        .cs_start_i  (cs_start),
        .cs_active_i (cs_active),
        .tx_byte_o   (tx_byte),
        .stall_o     (spi_stall_o),
        .req_o       (req),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready),
        .rsp_i       (rsp)
    );

    bus_ram u_ram (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .rsp_o       (rsp)
    );

endmodule

// ==== hdl/bus_ram.sv ====
// Byte-wide bus RAM; decodes only the low RAM_ADDR_BITS, acks every request after one cycle
`include "spi_bus_consts.svh"

module bus_ram (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  spi_bus_pkg::bus_req_t req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output spi_bus_pkg::bus_rsp_t rsp_o
);

    localparam int DEPTH = 1 << `RAM_ADDR_BITS;

    logic [`SPI_DATA_W-1:0]    mem [DEPTH];
    logic [`RAM_ADDR_BITS-1:0] waddr;

    assign waddr = req_i.addr[`RAM_ADDR_BITS-1:0];   // Upper bits alias

    // Ready pulses once per request
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_ready_o <= 1'b0;
        end else begin
            req_ready_o <= req_valid_i & ~req_ready_o;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o && req_i.we) begin
            mem[waddr] <= req_i.wdata;
        end
        if (req_valid_i && !req_ready_o) begin
            rsp_o.rdata <= mem[waddr];  // Lines up with ready
        end
    end

endmodule

// ==== spi1/spi1_controller.sv ====
// Command sequencer issuing one bus cycle per command and dropping partial commands on cs release
`include "spi_bus_consts.svh"

module spi1_controller (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [`SPI_DATA_W-1:0] rx_byte_i,
    input  logic                   rx_valid_i,
    input  logic                   cs_start_i,
    input  logic                   cs_active_i,
    output logic [`SPI_DATA_W-1:0] tx_byte_o,
    output logic                   stall_o,
    output spi_bus_pkg::bus_req_t  req_o,
    output logic                   req_valid_o,
    input  logic                   req_ready_i,
    input  spi_bus_pkg::bus_rsp_t  rsp_i
);

    spi_bus_pkg::spi_op_e   op_in;      // Opcode of the byte arriving now
    spi_bus_pkg::spi_op_e   op_q;       // Opcode of the command in progress
    logic [1:0]             byte_idx;   // 0 = command, 1 = addr hi, 2 = addr lo, 3 = data
    logic [`SPI_ADDR_W-1:0] addr_q;
    logic [`SPI_ADDR_W-1:0] last_addr_q;

    logic                   byte_rx;
    logic                   issue;
    logic                   issue_we;
    logic [`SPI_ADDR_W-1:0] issue_addr;

    always_comb begin
        case (rx_byte_i[7:5])
            `OP_WRITE_AT:  op_in = spi_bus_pkg::OP_WR_AT;
            `OP_READ_AT:   op_in = spi_bus_pkg::OP_RD_AT;
            `OP_READ_NEXT: op_in = spi_bus_pkg::OP_RD_NEXT;
            default:       op_in = spi_bus_pkg::OP_NONE;
        endcase
    end

    // Bytes arriving during a bus cycle are ignored since the host waits on stall
    assign byte_rx = rx_valid_i & cs_active_i & ~req_valid_o;

    always_comb begin
        issue      = 1'b0;
        issue_we   = 1'b0;
        issue_addr = {addr_q[`SPI_ADDR_W-1:8], rx_byte_i};
        case (byte_idx)
            2'd0: begin
                if (byte_rx && op_in == spi_bus_pkg::OP_RD_NEXT) begin
                    issue      = 1'b1;
                    issue_addr = last_addr_q + {{(`SPI_ADDR_W-1){1'b0}}, 1'b1};   // Wraps at 17 bits
                end
            end
            2'd2: begin
                issue = byte_rx & (op_q == spi_bus_pkg::OP_RD_AT);
            end
            2'd3: begin
                issue      = byte_rx;
                issue_we   = 1'b1;
                issue_addr = addr_q;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            byte_idx    <= 2'd0;
            op_q        <= spi_bus_pkg::OP_NONE;
            req_valid_o <= 1'b0;
            stall_o     <= 1'b0;
            tx_byte_o   <= '0;
        end else if (!cs_active_i || cs_start_i) begin
            byte_idx    <= 2'd0;    // Abandon anything pending
            req_valid_o <= 1'b0;
            stall_o     <= 1'b0;
        end else begin
            if (req_valid_o && req_ready_i) begin
                req_valid_o <= 1'b0;
                stall_o     <= 1'b0;
                if (!req_o.we) begin
                    tx_byte_o <= rsp_i.rdata;   // Reply for the next SPI byte
                end
            end
            if (issue) begin
                req_valid_o <= 1'b1;
                stall_o     <= 1'b1;
            end
            if (byte_rx) begin
                case (byte_idx)
                    2'd0: begin
                        op_q <= op_in;
                        if (op_in == spi_bus_pkg::OP_WR_AT ||
                            op_in == spi_bus_pkg::OP_RD_AT) begin
                            byte_idx <= 2'd1;
                        end
                    end
                    2'd1: byte_idx <= 2'd2;
                    2'd2: byte_idx <= (op_q == spi_bus_pkg::OP_WR_AT) ? 2'd3 : 2'd0;
                    default: byte_idx <= 2'd0;
                endcase
            end
        end
    end

    // Address and request payload
    always_ff @(posedge clk) begin
        if (byte_rx) begin
            case (byte_idx)
                2'd0: addr_q[`SPI_ADDR_W-1] <= rx_byte_i[0];   // Address bit 16
                2'd1: addr_q[15:8] <= rx_byte_i;
                2'd2: addr_q[7:0]  <= rx_byte_i;
                default: ;
            endcase
        end
        if (issue) begin
            req_o.addr  <= issue_addr;
            req_o.wdata <= rx_byte_i;   // Only meaningful for WRITE_AT
            req_o.we    <= issue_we;
            last_addr_q <= issue_addr;
        end
    end

endmodule

// ==== spi1/spi_byte_link.sv ====
// SPI mode 0 byte link, MSB first; pins are synchronized so sck must not exceed clk/8
`include "spi_bus_consts.svh"

module spi_byte_link (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   spi_sck_i,
    input  logic                   spi_cs_n_i,
    input  logic                   spi_pico_i,
    output logic                   spi_poci_o,
    input  logic [`SPI_DATA_W-1:0] tx_byte_i,
    output logic [`SPI_DATA_W-1:0] rx_byte_o,
    output logic                   rx_valid_o,
    output logic                   cs_start_o,
    output logic                   cs_active_o
);

    logic [1:0] sck_sync;   // Two-flop synchronizers
    logic [1:0] cs_n_sync;
    logic [1:0] pico_sync;
    logic       sck_d;      // Previous synchronized level
    logic       cs_n_d;

    logic       sck_rise;
    logic       sck_fall;
    logic       cs_fall;
    logic       cs_on;

    logic [2:0]             bit_cnt;
    logic [`SPI_DATA_W-1:0] rx_shift;
    logic [`SPI_DATA_W-1:0] tx_shift;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sck_sync  <= 2'b00;
            cs_n_sync <= 2'b11;     // Bus idles deselected
            pico_sync <= 2'b00;
            sck_d     <= 1'b0;
            cs_n_d    <= 1'b1;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n_i};
            pico_sync <= {pico_sync[0], spi_pico_i};
            sck_d     <= sck_sync[1];
            cs_n_d    <= cs_n_sync[1];
        end
    end

    assign cs_on    = ~cs_n_sync[1];
    assign sck_rise = cs_on &  sck_sync[1] & ~sck_d;
    assign sck_fall = cs_on & ~sck_sync[1] &  sck_d;
    assign cs_fall  = ~cs_n_sync[1] & cs_n_d;

    // Receive side; a byte completes on the eighth rising edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt     <= 3'd0;
            rx_shift    <= '0;
            rx_byte_o   <= '0;
            rx_valid_o  <= 1'b0;
            cs_start_o  <= 1'b0;
            cs_active_o <= 1'b0;
        end else begin
            rx_valid_o  <= 1'b0;
            cs_start_o  <= cs_fall;
            cs_active_o <= cs_on;
            if (!cs_on) begin
                bit_cnt <= 3'd0;    // Drop any partial byte
            end else if (sck_rise) begin
                rx_shift <= {rx_shift[`SPI_DATA_W-2:0], pico_sync[1]};
                bit_cnt  <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_byte_o  <= {rx_shift[`SPI_DATA_W-2:0], pico_sync[1]};
                    rx_valid_o <= 1'b1;
                end
            end
        end
    end

    // Transmit side; reload between bytes so late reply data is still picked up
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_shift <= '0;
        end else if (bit_cnt == 3'd0 && !sck_rise) begin
            tx_shift <= tx_byte_i;  // MSB presented before first rising edge
        end else if (sck_fall) begin
            tx_shift <= {tx_shift[`SPI_DATA_W-2:0], 1'b0};
        end
    end

    assign spi_poci_o = tx_shift[`SPI_DATA_W-1];

endmodule

// ==== common/spi_bus_pkg.sv ====
// Bus types for the SPI bridge; one outstanding request at a time, no error response
`include "spi_bus_consts.svh"

package spi_bus_pkg;

    // Request from the command sequencer to the memory bus
    typedef struct packed {
        logic [`SPI_ADDR_W-1:0] addr;   // Full 17-bit address
        logic [`SPI_DATA_W-1:0] wdata;  // Write data, ignored on reads
        logic                   we;     // 1 = write
    } bus_req_t;

    // Response returned with the acknowledge
    typedef struct packed {
        logic [`SPI_DATA_W-1:0] rdata;  // Valid with ready on reads
    } bus_rsp_t;

    // Decoded command; OP_NONE covers every unused opcode
    typedef enum logic [2:0] {
        OP_NONE    = 3'b000,
        OP_WR_AT   = `OP_WRITE_AT,
        OP_RD_AT   = `OP_READ_AT,
        OP_RD_NEXT = `OP_READ_NEXT
    } spi_op_e;

endpackage

// ==== common/spi_bus_consts.svh ====
// Widths and opcodes shared by the bridge; RAM depth is 2**RAM_ADDR_BITS, upper bits alias
`ifndef SPI_BUS_CONSTS_SVH
`define SPI_BUS_CONSTS_SVH

// Bus geometry
`define SPI_ADDR_W     17
`define SPI_DATA_W     8

// Address bits decoded by the on-chip RAM
`define RAM_ADDR_BITS  10

// Opcodes carried in bits [7:5] of the command byte
`define OP_WRITE_AT    3'b100
`define OP_READ_AT     3'b110
`define OP_READ_NEXT   3'b111

`endif
